// File: mmc_pkg.sv
package mmc_pkg;

  // active data lines
  localparam logic [1:0] DW_1 = 2'd0;
  localparam logic [1:0] DW_4 = 2'd1;
  localparam logic [1:0] DW_8 = 2'd2;

  // transfer kinds
  localparam logic [1:0] ADV_CMD_RD = 2'd0;
  localparam logic [1:0] ADV_CMD_WR = 2'd1;
  localparam logic [1:0] ADV_DAT_RD = 2'd2;
  localparam logic [1:0] ADV_DAT_WR = 2'd3;

  // bus addresses
  localparam logic [1:0] REG_CFG    = 2'd0;
  localparam logic [1:0] REG_XFER   = 2'd1;
  localparam logic [1:0] REG_STATUS = 2'd2;

  localparam int DIV_W = 8;   // card clock divider field
  localparam int REG_W = 12;  // bus word

  typedef struct packed {
    logic [1:0]       width;
    logic [DIV_W-1:0] divider;
  } mmc_cfg_t;

  typedef struct packed {
    logic [1:0] pad;
    mmc_cfg_t   cfg;
  } mmc_cfg_word_t;

  typedef struct packed {
    logic [1:0] mode;
    logic [7:0] send_byte;
    logic [1:0] pad;
  } mmc_xfer_t;

  // one bus word, decoded by the address it is written to
  typedef union packed {
    mmc_cfg_word_t cfg_word;
    mmc_xfer_t     xfer;
  } mmc_reg_word_u;

  typedef struct packed {
    logic       card_clk;
    logic       cmd_out;
    logic       cmd_oe;
    logic [7:0] dat_out;
    logic [7:0] dat_oe;  // one per line
  } mmc_pins_out_t;

  typedef struct packed {
    logic       cmd_in;
    logic [7:0] dat_in;
  } mmc_pins_in_t;

endpackage

// File: mmc_regs.sv
module mmc_regs (
  input  logic                       clk,
  input  logic                       reset_i,

  input  logic                       wr_en_i,
  input  logic [1:0]                 addr_i,
  input  mmc_pkg::mmc_reg_word_u     wr_data_i,

  input  logic                       busy_i,
  input  logic                       done_i,
  input  logic [7:0]                 rd_byte_i,

  output logic [mmc_pkg::REG_W-1:0]  rd_data_o,
  output mmc_pkg::mmc_cfg_t          cfg_o,
  output logic                       start_o,
  output mmc_pkg::mmc_xfer_t         xfer_o
);

  logic locked;
  logic cfg_wr;
  logic xfer_wr;

  // start_o covers the cycle before the controller raises busy
  assign locked  = busy_i || start_o;
  assign cfg_wr  = wr_en_i && (addr_i == mmc_pkg::REG_CFG) && !locked;
  assign xfer_wr = wr_en_i && (addr_i == mmc_pkg::REG_XFER) && !locked;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      cfg_o.width   <= mmc_pkg::DW_1;
      cfg_o.divider <= '0;
    end else if (cfg_wr) begin
      cfg_o <= wr_data_i.cfg_word.cfg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      start_o <= 1'b0;
    end else begin
      start_o <= xfer_wr;  // one cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (xfer_wr) begin
      xfer_o <= wr_data_i.xfer;
    end
  end

  always_comb begin
    case (addr_i)
      mmc_pkg::REG_CFG: begin
        rd_data_o = {2'b00, cfg_o};
      end
      mmc_pkg::REG_XFER: begin
        rd_data_o = xfer_o;
      end
      mmc_pkg::REG_STATUS: begin
        rd_data_o = {2'b00, done_i, busy_i, rd_byte_i};
      end
      default: begin
        rd_data_o = '0;
      end
    endcase
  end

  // the controller must not already be busy when a new byte launches
  a_start_idle: assert property (
    @(posedge clk) disable iff (reset_i)
    start_o |-> !busy_i
  );

endmodule

// File: mmc_clk_gen.sv
module mmc_clk_gen (
  input  logic                      clk,
  input  logic                      reset_i,

  input  logic [mmc_pkg::DIV_W-1:0] divider_i,
  input  logic                      tick_i,

  output logic                      card_clk_o,
  output logic                      clk_ack_o,
  output logic                      clk_done_o
);

  logic [mmc_pkg::DIV_W-1:0] cnt;
  logic                      half_end;

  assign half_end = (cnt == divider_i);  // divider+1 cycles per half period

  always_ff @(posedge clk) begin
    if (reset_i || !tick_i) begin
      cnt        <= '0;
      card_clk_o <= 1'b0;  // park low between bytes
      clk_ack_o  <= 1'b0;
      clk_done_o <= 1'b0;
    end else begin
      clk_ack_o  <= half_end && card_clk_o;   // falling edge, outputs move
      clk_done_o <= half_end && !card_clk_o;  // rising edge, inputs sampled
      if (half_end) begin
        cnt        <= '0;
        card_clk_o <= ~card_clk_o;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Each pulse marks exactly one card clock edge, so the two can never
  // coincide even when the divider is zero.
  a_ack_done_excl: assert property (
    @(posedge clk) disable iff (reset_i)
    !(clk_ack_o && clk_done_o)
  );

endmodule

// File: mmc_adv_proc.sv
module mmc_adv_proc (
  input  logic                  clk,
  input  logic                  reset_i,

  input  logic [1:0]            adv_mode_i,
  input  logic                  adv_en_i,
  input  logic [1:0]            width_i,
  input  logic [7:0]            send_byte_i,

  input  mmc_pkg::mmc_pins_in_t pins_i,

  input  logic                  clk_ack_i,
  input  logic                  clk_done_i,

  output logic                  adv_tick_o,
  output logic                  adv_done_o,
  output logic [7:0]            rd_byte_o,

  output logic                  cmd_out_o,
  output logic [7:0]            dat_out_o
);

  logic       busy_q;
  logic       cmd_mode;
  logic [2:0] len_m1;
  logic [2:0] wr_index;
  logic [2:0] rd_index;
  logic       bit_in;
  logic [6:0] accum;

  assign cmd_mode = (adv_mode_i == mmc_pkg::ADV_CMD_RD) || (adv_mode_i == mmc_pkg::ADV_CMD_WR);

  // last sample index of the byte
  always_comb begin
    if (cmd_mode) begin
      len_m1 = 3'd7;
    end else begin
      case (width_i)
        mmc_pkg::DW_1: len_m1 = 3'd7;
        mmc_pkg::DW_4: len_m1 = 3'd1;
        default:       len_m1 = 3'd0;
      endcase
    end
  end

  assign adv_done_o = busy_q && clk_done_i && (rd_index == len_m1);
  assign adv_tick_o = adv_en_i || (busy_q && !adv_done_o);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q <= 1'b0;
    end else if (adv_en_i) begin
      busy_q <= 1'b1;
    end else if (adv_done_o) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || adv_en_i) begin
      wr_index <= 3'd0;
    end else if (clk_ack_i && busy_q) begin
      wr_index <= wr_index + 3'd1;
    end
  end

  // MSB part leads, so index 0 is on the lines before the first rising edge
  assign cmd_out_o = send_byte_i[3'd7 - wr_index];

  always_comb begin
    case (width_i)
      mmc_pkg::DW_1: dat_out_o = {7'b0, send_byte_i[3'd7 - wr_index]};
      mmc_pkg::DW_4: dat_out_o = {4'b0, (wr_index[0] ? send_byte_i[3:0] : send_byte_i[7:4])};
      default:       dat_out_o = send_byte_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i || adv_en_i || adv_done_o) begin
      rd_index <= 3'd0;
    end else if (clk_done_i && busy_q) begin
      rd_index <= rd_index + 3'd1;
    end
  end

  assign bit_in = cmd_mode ? pins_i.cmd_in : pins_i.dat_in[0];  // serial source

  always_ff @(posedge clk) begin
    if (clk_done_i) begin
      if (!cmd_mode && (width_i == mmc_pkg::DW_4)) begin
        accum[3:0] <= pins_i.dat_in[3:0];
      end else begin
        accum <= {accum[5:0], bit_in};
      end
    end
  end

  // last part comes straight from the pins on the final sample
  always_comb begin
    if (cmd_mode || (width_i == mmc_pkg::DW_1)) begin
      rd_byte_o = {accum, bit_in};
    end else if (width_i == mmc_pkg::DW_4) begin
      rd_byte_o = {accum[3:0], pins_i.dat_in[3:0]};
    end else begin
      rd_byte_o = pins_i.dat_in;
    end
  end

  a_rd_index_len: assert property (
    @(posedge clk) disable iff (reset_i)
    busy_q |-> (rd_index <= len_m1)
  );

endmodule

// File: mmc_xfer_ctrl.sv
module mmc_xfer_ctrl (
  input  logic               clk,
  input  logic               reset_i,

  input  logic               start_i,
  input  mmc_pkg::mmc_xfer_t xfer_i,
  input  mmc_pkg::mmc_cfg_t  cfg_i,

  input  logic               adv_done_i,
  input  logic [7:0]         rd_byte_i,

  output logic               adv_en_o,
  output logic [1:0]         adv_mode_o,
  output logic [7:0]         send_byte_o,

  output logic               cmd_oe_o,
  output logic [7:0]         dat_oe_o,

  output logic               busy_o,
  output logic               done_o,
  output logic [7:0]         rd_byte_o
);

  logic [7:0] width_mask;
  logic       is_read;

  always_comb begin
    case (cfg_i.width)
      mmc_pkg::DW_1: width_mask = 8'h01;
      mmc_pkg::DW_4: width_mask = 8'h0f;
      default:       width_mask = 8'hff;
    endcase
  end

  assign is_read = (adv_mode_o == mmc_pkg::ADV_CMD_RD) || (adv_mode_o == mmc_pkg::ADV_DAT_RD);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      adv_en_o <= 1'b0;
      cmd_oe_o <= 1'b0;
      dat_oe_o <= '0;
      busy_o   <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      adv_en_o <= start_i;
      if (start_i) begin
        busy_o   <= 1'b1;
        done_o   <= 1'b0;  // cleared by the next transfer
        cmd_oe_o <= (xfer_i.mode == mmc_pkg::ADV_CMD_WR);
        dat_oe_o <= (xfer_i.mode == mmc_pkg::ADV_DAT_WR) ? width_mask : 8'h00;
      end else if (adv_done_i) begin
        busy_o   <= 1'b0;
        done_o   <= 1'b1;  // sticky
        cmd_oe_o <= 1'b0;
        dat_oe_o <= '0;
      end
    end
  end

  // held for the shifter for the whole byte
  always_ff @(posedge clk) begin
    if (start_i) begin
      adv_mode_o  <= xfer_i.mode;
      send_byte_o <= xfer_i.send_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_done_i && is_read) begin
      rd_byte_o <= rd_byte_i;
    end
  end

  // the shifter may only finish a byte that this controller launched
  a_done_while_busy: assert property (
    @(posedge clk) disable iff (reset_i)
    adv_done_i |-> busy_o
  );

endmodule

// File: mmc_host_top.sv
module mmc_host_top (
  input  logic                      clk,
  input  logic                      reset_i,

  input  logic                      wr_en_i,
  input  logic [1:0]                addr_i,
  input  mmc_pkg::mmc_reg_word_u    wr_data_i,
  output logic [mmc_pkg::REG_W-1:0] rd_data_o,

  input  mmc_pkg::mmc_pins_in_t     pins_i,
  output mmc_pkg::mmc_pins_out_t    pins_o
);

  mmc_pkg::mmc_cfg_t  cfg;
  mmc_pkg::mmc_xfer_t xfer;
  logic               start;
  logic               busy;
  logic               done;
  logic [7:0]         ctrl_rd_byte;
  logic               adv_en;
  logic [1:0]         adv_mode;
  logic [7:0]         send_byte;
  logic               adv_tick;
  logic               adv_done;
  logic [7:0]         adv_rd_byte;
  logic               clk_ack;
  logic               clk_done;
  logic               card_clk;
  logic               cmd_out;
  logic               cmd_oe;
  logic [7:0]         dat_out;
  logic [7:0]         dat_oe;

  mmc_regs u_regs (
    .clk       (clk),
    .reset_i   (reset_i),
    .wr_en_i   (wr_en_i),
    .addr_i    (addr_i),
    .wr_data_i (wr_data_i),
    .busy_i    (busy),
    .done_i    (done),
    .rd_byte_i (ctrl_rd_byte),
    .rd_data_o (rd_data_o),
    .cfg_o     (cfg),
    .start_o   (start),
    .xfer_o    (xfer)
  );

  mmc_xfer_ctrl u_ctrl (
    .clk         (clk),
    .reset_i     (reset_i),
    .start_i     (start),
    .xfer_i      (xfer),
    .cfg_i       (cfg),
    .adv_done_i  (adv_done),
    .rd_byte_i   (adv_rd_byte),
    .adv_en_o    (adv_en),
    .adv_mode_o  (adv_mode),
    .send_byte_o (send_byte),
    .cmd_oe_o    (cmd_oe),
    .dat_oe_o    (dat_oe),
    .busy_o      (busy),
    .done_o      (done),
    .rd_byte_o   (ctrl_rd_byte)
  );

  mmc_clk_gen u_clk (
    .clk        (clk),
    .reset_i    (reset_i),
    .divider_i  (cfg.divider),
    .tick_i     (adv_tick),
    .card_clk_o (card_clk),
    .clk_ack_o  (clk_ack),
    .clk_done_o (clk_done)
  );

  mmc_adv_proc u_adv (
    .clk         (clk),
    .reset_i     (reset_i),
    .adv_mode_i  (adv_mode),
    .adv_en_i    (adv_en),
    .width_i     (cfg.width),
    .send_byte_i (send_byte),
    .pins_i      (pins_i),
    .clk_ack_i   (clk_ack),
    .clk_done_i  (clk_done),
    .adv_tick_o  (adv_tick),
    .adv_done_o  (adv_done),
    .rd_byte_o   (adv_rd_byte),
    .cmd_out_o   (cmd_out),
    .dat_out_o   (dat_out)
  );

  assign pins_o.card_clk = card_clk;
  assign pins_o.cmd_out  = cmd_out;
  assign pins_o.cmd_oe   = cmd_oe;
  assign pins_o.dat_out  = dat_out;
  assign pins_o.dat_oe   = dat_oe;

endmodule

// File: tb_mmc_host.sv
module tb_mmc_host;

  localparam int TIMEOUT = 5000;  // clk cycles per wait

  logic                            clk;
  logic                            reset_i;
  logic                            wr_en_i;
  logic [1:0]                      addr_i;
  mmc_pkg::mmc_reg_word_u          wr_data_i;
  logic [mmc_pkg::REG_W-1:0]       rd_data_o;
  mmc_pkg::mmc_pins_in_t           pins_i;
  mmc_pkg::mmc_pins_out_t          pins_o;

  integer seed;
  int     err_cnt, pass_cnt, fail_cnt;

  // card model state, set by the main process while the card clock is parked
  logic       card_cmd;
  logic [1:0] card_width;
  logic [7:0] card_byte;
  int         cur_div;
  int         rise_cnt, fall_cnt, cyc, last_rise;
  logic       card_clk_q;
  logic       s_cmd[0:7];
  logic       s_cmd_oe[0:7];
  logic [7:0] s_dat[0:7];
  logic [7:0] s_dat_oe[0:7];

  mmc_host_top u_dut (
    .clk       (clk),
    .reset_i   (reset_i),
    .wr_en_i   (wr_en_i),
    .addr_i    (addr_i),
    .wr_data_i (wr_data_i),
    .rd_data_o (rd_data_o),
    .pins_i    (pins_i),
    .pins_o    (pins_o)
  );

  always #10 clk = ~clk;

  task automatic check_val(input string name, input logic [11:0] exp_v, input logic [11:0] act_v);
    if (act_v !== exp_v) begin
      $display("ERROR at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  // part of the card byte that sits on the lines after idx falling edges
  function automatic mmc_pkg::mmc_pins_in_t card_part(input logic is_cmd, input logic [1:0] w,
                                                      input logic [7:0] b, input int idx);
    mmc_pkg::mmc_pins_in_t p;
    int k;
    k = (idx > 7) ? 7 : idx;
    p.cmd_in = 1'b1;  // unused lines idle high
    p.dat_in = 8'hff;
    if (is_cmd) begin
      p.cmd_in = b[7-k];
    end else if (w == mmc_pkg::DW_1) begin
      p.dat_in[0] = b[7-k];
    end else if (w == mmc_pkg::DW_4) begin
      p.dat_in[3:0] = (k == 0) ? b[7:4] : b[3:0];
    end else begin
      p.dat_in = b;
    end
    return p;
  endfunction

  always @(posedge clk) begin
    pins_i <= card_part(card_cmd, card_width, card_byte, fall_cnt);
  end

  // card side monitor, looks at the pins half a clk cycle after they move
  always @(negedge clk) begin
    cyc        <= cyc + 1;
    card_clk_q <= pins_o.card_clk;
    if (pins_o.card_clk && !card_clk_q) begin
      if (rise_cnt > 0) begin
        check_val("card_clk period", 2 * (cur_div + 1), cyc - last_rise);
      end
      if (rise_cnt < 8) begin
        s_cmd[rise_cnt]    <= pins_o.cmd_out;
        s_cmd_oe[rise_cnt] <= pins_o.cmd_oe;
        s_dat[rise_cnt]    <= pins_o.dat_out;
        s_dat_oe[rise_cnt] <= pins_o.dat_oe;
      end
      rise_cnt  <= rise_cnt + 1;
      last_rise <= cyc;
    end
    if (!pins_o.card_clk && card_clk_q) begin
      fall_cnt <= fall_cnt + 1;
    end
  end

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset_i <= 1'b1;
    wr_en_i <= 1'b0;
    addr_i  <= mmc_pkg::REG_STATUS;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;
  endtask

  task automatic write_reg(input logic [1:0] a, input mmc_pkg::mmc_reg_word_u d);
    @(posedge clk);
    wr_en_i   <= 1'b1;
    addr_i    <= a;
    wr_data_i <= d;
    @(posedge clk);
    wr_en_i <= 1'b0;
    addr_i  <= mmc_pkg::REG_STATUS;  // status stays visible between writes
  endtask

  task automatic wait_status(input int bit_pos, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (rd_data_o[bit_pos] !== 1'b1 && n < TIMEOUT) begin
      n++;
      @(negedge clk);
    end
    if (n >= TIMEOUT) begin
      stop_on_timeout(what);
    end
  endtask

  task automatic run_xfer(input int op, input int wl, input int dv, input logic [7:0] b,
                          input logic [7:0] ev);
    mmc_pkg::mmc_reg_word_u word;
    logic [1:0]             w;
    logic [1:0]             mode;
    logic [7:0]             mask, cb, exp_byte, got, exp_dat_oe;
    logic                   is_cmd, is_wr, exp_cmd_oe;
    integer                 rnd;
    int                     edges, i;
    w    = (wl == 8) ? mmc_pkg::DW_8 : (wl == 4) ? mmc_pkg::DW_4 : mmc_pkg::DW_1;
    mask = (wl == 8) ? 8'hff : (wl == 4) ? 8'h0f : 8'h01;
    case (op)
      1:       mode = mmc_pkg::ADV_CMD_WR;
      2, 7:    mode = mmc_pkg::ADV_DAT_WR;
      3, 5:    mode = mmc_pkg::ADV_CMD_RD;
      default: mode = mmc_pkg::ADV_DAT_RD;
    endcase
    is_cmd     = (mode == mmc_pkg::ADV_CMD_WR) || (mode == mmc_pkg::ADV_CMD_RD);
    is_wr      = (mode == mmc_pkg::ADV_CMD_WR) || (mode == mmc_pkg::ADV_DAT_WR);
    edges      = is_cmd ? 8 : (wl == 8) ? 1 : (wl == 4) ? 2 : 8;
    exp_cmd_oe = (mode == mmc_pkg::ADV_CMD_WR);
    exp_dat_oe = (mode == mmc_pkg::ADV_DAT_WR) ? mask : 8'h00;
    cb         = b;
    exp_byte   = ev;
    if (op == 5 || op == 6) begin
      rnd      = $random(seed);
      cb       = rnd[7:0];
      exp_byte = cb;
    end

    word = '0;
    word.cfg_word.cfg.width   = w;
    word.cfg_word.cfg.divider = dv[7:0];
    write_reg(mmc_pkg::REG_CFG, word);

    @(negedge clk);
    card_cmd   = is_cmd;
    card_width = w;
    card_byte  = cb;
    cur_div    = dv;
    rise_cnt   = 0;
    fall_cnt   = 0;

    word = '0;
    word.xfer.mode      = mode;
    word.xfer.send_byte = b;
    write_reg(mmc_pkg::REG_XFER, word);
    // done of the previous byte stays up until the new byte is under way
    wait_status(8, "busy after the transfer write");
    if (op == 7) begin
      word.xfer.send_byte = ~b;  // must never reach the pins
      write_reg(mmc_pkg::REG_XFER, word);
    end
    wait_status(9, "done");

    check_val("card_clk rises", edges, rise_cnt);
    got = 8'h00;
    for (i = 0; i < rise_cnt && i < 8; i++) begin
      if (is_cmd) begin
        got = {got[6:0], s_cmd[i]};
      end else if (wl == 1) begin
        got = {got[6:0], s_dat[i][0]};
      end else if (wl == 4) begin
        got = {got[3:0], s_dat[i][3:0]};
      end else begin
        got = s_dat[i];
      end
      check_val("cmd_oe", exp_cmd_oe, s_cmd_oe[i]);
      check_val("dat_oe", exp_dat_oe, s_dat_oe[i]);
    end
    if (is_wr) begin
      check_val("byte on pins", exp_byte, got);
    end else begin
      check_val("status read byte", exp_byte, rd_data_o[7:0]);
    end

    if (op == 7) begin
      for (i = 0; i < 4 * (dv + 1) + 10; i++) begin
        @(negedge clk);
      end
      check_val("card_clk rises after hold", edges, rise_cnt);
    end
    check_val("status busy", 12'd0, rd_data_o[8]);
    check_val("status done", 12'd1, rd_data_o[9]);
  endtask

  initial begin
    int                 fd, r, n, op, wl, dv, tnum, err_before;
    logic [7:0]         b, ev;
    logic [8*96-1:0]    line;
    clk        = 1'b0;
    reset_i    = 1'b1;
    wr_en_i    = 1'b0;
    addr_i     = mmc_pkg::REG_STATUS;
    wr_data_i  = '0;
    pins_i     = '0;
    seed       = 39576;
    card_cmd   = 1'b1;
    card_width = mmc_pkg::DW_1;
    card_byte  = 8'h00;
    cur_div    = 0;
    rise_cnt   = 0;
    fall_cnt   = 0;
    cyc        = 0;
    last_rise  = 0;
    card_clk_q = 1'b0;
    err_cnt    = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    tnum       = 0;

    fd = $fopen("mmc_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open mmc_stimulus.txt");
      $display("Test FAILED");
      $finish;
    end else begin
      apply_reset();
      while (!$feof(fd)) begin
        line = '0;
        r    = $fgets(line, fd);
        n    = $sscanf(line, "%d %d %d %h %h", op, wl, dv, b, ev);
        if (r > 0 && n == 5) begin  // comment and blank lines fall through
          tnum++;
          err_before = err_cnt;
          if (op == 0) begin
            apply_reset();
            @(negedge clk);
            check_val("card_clk", 12'd0, pins_o.card_clk);
            check_val("cmd_oe", 12'd0, pins_o.cmd_oe);
            check_val("dat_oe", 12'd0, pins_o.dat_oe);
            check_val("status busy", 12'd0, rd_data_o[8]);
            check_val("status done", 12'd0, rd_data_o[9]);
          end else begin
            run_xfer(op, wl, dv, b, ev);
          end
          if (err_cnt == err_before) begin
            pass_cnt++;
          end else begin
            fail_cnt++;
          end
          $display("test %0d op %0d width %0d div %0d: %s", tnum, op, wl, dv,
                   (err_cnt == err_before) ? "pass" : "fail");
        end
      end
      $fclose(fd);
      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0 && pass_cnt > 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
      $finish;
    end
  end

endmodule

// File: mmc_stimulus.txt
# op: 0 reset, 1 cmd write, 2 data write, 3 cmd read, 4 data read, 5 cmd read random,
# 6 data read random, 7 data write with a dropped second write; then width divider byte expected
0 1 0 00 00
1 1 0 a5 a5
1 1 3 3c 3c
2 1 1 96 96
2 4 2 c3 c3
2 8 0 5a 5a
2 8 4 e1 e1
3 1 2 b7 b7
3 1 0 48 48
4 1 1 d2 d2
4 4 0 6e 6e
4 4 5 19 19
4 8 2 f0 f0
5 1 1 00 00
5 1 4 00 00
6 1 0 00 00
6 4 3 00 00
6 8 1 00 00
7 1 2 81 81
7 4 3 7e 7e
1 1 7 01 01
2 4 0 0f 0f
0 1 0 00 00

// File: vlog.f
mmc_pkg.sv
mmc_regs.sv
mmc_clk_gen.sv
mmc_adv_proc.sv
mmc_xfer_ctrl.sv
mmc_host_top.sv
tb_mmc_host.sv
